/* hw/raster_pkg.sv */
// raster_pkg: bitmap constants, coordinate and colour types,
// queued command and pixel write structs, fixed palette function
package raster_pkg;

    // bitmap geometry
    localparam int FB_W      = 32;            // width in pixels
    localparam int FB_H      = 24;            // height in pixels
    localparam int FB_PIXELS = FB_W * FB_H;   // 768 pixels
    localparam int FB_ADDRW  = 10;            // enough for FB_PIXELS

    localparam int CORDW = 8;   // signed coordinate width
    localparam int CIDXW = 4;   // colour index width
    localparam int COLRW = 12;  // 4 bits each of r, g, b

    typedef logic signed [CORDW-1:0] coord_t;
    typedef logic [CIDXW-1:0]        cidx_t;
    typedef logic [FB_ADDRW-1:0]     fb_addr_t;
    typedef logic [COLRW-1:0]        rgb_t;

    // one draw request, both endpoints inclusive
    typedef struct packed {
        coord_t x0;
        coord_t y0;
        coord_t x1;
        coord_t y1;
        cidx_t  cidx;
    } line_cmd_t;

    // one framebuffer write, address already clipped
    typedef struct packed {
        fb_addr_t addr;
        cidx_t    cidx;
    } pix_wr_t;

    // fixed 16 entry palette, 4 bits per channel
    function automatic rgb_t palette_lookup(input cidx_t idx);
        case (idx)
            4'd0:    return 12'h112;  // near black, bitmap background
            4'd1:    return 12'h525;
            4'd2:    return 12'hb35;
            4'd3:    return 12'he75;
            4'd4:    return 12'hfc7;
            4'd5:    return 12'haf7;
            4'd6:    return 12'h3b6;
            4'd7:    return 12'h277;
            4'd8:    return 12'h236;
            4'd9:    return 12'h35c;
            4'd10:   return 12'h4af;
            4'd11:   return 12'h7ef;
            4'd12:   return 12'hfff;  // white
            4'd13:   return 12'h9bc;
            4'd14:   return 12'h568;
            default: return 12'h335;  // index 15
        endcase
    endfunction

endpackage

/* hw/credit_fifo.sv */
// credit_fifo: circular buffer for any payload type
// returns one credit pulse per entry popped, no back-pressure
`timescale 1ns/1ns

module credit_fifo #(
    parameter type T     = logic [7:0],  // payload type
    parameter int  DEPTH = 4             // entries, equals sender's starting credits
) (
    input  logic clk_sys,
    input  logic rst_sys,
    input  logic in_valid,   // write, sender guarantees space
    input  T     in_data,
    input  logic pop,        // consume head entry
    output T     out_data,   // head entry, valid while not empty
    output logic empty,
    output logic credit      // one cycle per popped entry
);

    localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;  // pointer width
    localparam int CW = $clog2(DEPTH + 1);                // count width

    T mem [DEPTH];  // storage, no reset needed

    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    logic [CW-1:0] count;  // occupied entries
    logic          do_pop;

    assign empty    = (count == '0);
    assign do_pop   = pop && !empty;  // ignore pop on empty queue
    assign out_data = mem[rd_ptr];    // first word fall through

    // payload write
    always_ff @(posedge clk_sys) begin
        if (in_valid) mem[wr_ptr] <= in_data;
    end

    // pointers, count and credit return
    always_ff @(posedge clk_sys) begin
        if (rst_sys) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            credit <= 1'b0;
        end else begin
            credit <= do_pop;  // credit one cycle after the pop
            if (in_valid) begin
                wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;  // wrap
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({in_valid, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // both or neither
            endcase
        end
    end

endmodule

/* hw/line_render.sv */
// line_render: takes line commands from the command queue, walks them
// with Bresenham stepping, clips per pixel and sends pixel writes under credit
`timescale 1ns/1ns

module line_render import raster_pkg::*; #(
    parameter int PIX_DEPTH = 8  // pixel queue depth, initial credits
) (
    input  logic      clk_sys,
    input  logic      rst_sys,
    input  line_cmd_t cmd,         // head of command queue
    input  logic      cmd_empty,
    output logic      cmd_pop,
    output logic      pix_valid,   // one pixel write this cycle
    output pix_wr_t   pix,
    input  logic      pix_credit,  // entry left the pixel queue
    output logic      active       // command in progress
);

    localparam int EW  = CORDW + 3;            // error term width, holds 2*err
    localparam int CRW = $clog2(PIX_DEPTH + 1);

    typedef enum logic [1:0] {
        S_IDLE,   // waiting for a command
        S_SETUP,  // spans and error term
        S_DRAW    // one pixel per cycle unless stalled
    } state_t;

    state_t    state;
    line_cmd_t cmd_r;     // latched command
    coord_t    x, y;      // current point
    logic      x_neg;     // x steps down
    logic      y_neg;     // y steps down
    logic signed [EW-1:0] dx;    // abs x span
    logic signed [EW-1:0] dy;    // negated abs y span
    logic signed [EW-1:0] err;
    logic [CRW-1:0]       credits;

    logic signed [EW-1:0] span_x, span_y;
    logic signed [EW-1:0] dx_init, dy_init;
    logic signed [EW-1:0] e2;
    logic step_x, step_y;
    logic at_end;
    logic in_bmp;
    logic stall;
    logic advance;

    // setup arithmetic, from latched endpoints
    always_comb begin
        span_x  = EW'($signed(cmd_r.x1)) - EW'($signed(cmd_r.x0));
        span_y  = EW'($signed(cmd_r.y1)) - EW'($signed(cmd_r.y0));
        dx_init = (span_x < 0) ? -span_x : span_x;
        dy_init = (span_y < 0) ? span_y : -span_y;  // always <= 0
    end

    // per pixel decisions
    always_comb begin
        e2      = err <<< 1;
        step_x  = (e2 >= dy);
        step_y  = (e2 <= dx);
        at_end  = (x == cmd_r.x1) && (y == cmd_r.y1);
        in_bmp  = (x >= 0) && (x < FB_W) && (y >= 0) && (y < FB_H);
        stall   = in_bmp && (credits == '0);      // hold position until credit back
        advance = (state == S_DRAW) && !stall;
    end

    assign cmd_pop   = (state == S_IDLE) && !cmd_empty;
    assign active    = (state != S_IDLE);
    assign pix_valid = (state == S_DRAW) && in_bmp && (credits != '0);

    // linear address y*FB_W + x, only meaningful when in_bmp
    always_comb begin
        pix.addr = fb_addr_t'(y) * fb_addr_t'(FB_W) + fb_addr_t'(x);
        pix.cidx = cmd_r.cidx;
    end

    // control FSM
    always_ff @(posedge clk_sys) begin
        if (rst_sys) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE:  if (cmd_pop) state <= S_SETUP;
                S_SETUP: state <= S_DRAW;
                S_DRAW:  if (advance && at_end) state <= S_IDLE;  // last pixel done
                default: state <= S_IDLE;
            endcase
        end
    end

    // walker datapath, no reset
    always_ff @(posedge clk_sys) begin
        if (cmd_pop) cmd_r <= cmd;
        if (state == S_SETUP) begin
            x     <= cmd_r.x0;
            y     <= cmd_r.y0;
            x_neg <= (span_x < 0);
            y_neg <= (span_y < 0);
            dx    <= dx_init;
            dy    <= dy_init;
            err   <= dx_init + dy_init;
        end else if (advance && !at_end) begin
            if (step_x) x <= x_neg ? x - 1'b1 : x + 1'b1;
            if (step_y) y <= y_neg ? y - 1'b1 : y + 1'b1;
            err <= err + (step_x ? dy : '0) + (step_y ? dx : '0);
        end
    end

    // pixel credit counter
    always_ff @(posedge clk_sys) begin
        if (rst_sys) begin
            credits <= CRW'(PIX_DEPTH);  // queue starts empty
        end else begin
            case ({pix_valid, pix_credit})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

endmodule

/* hw/framebuffer.sv */
// framebuffer: bitmap of colour indices, write port drains the pixel queue,
// registered read port for scanout
`timescale 1ns/1ns

module framebuffer import raster_pkg::*; (
    input  logic     clk_sys,
    input  logic     wr_empty,  // pixel queue empty
    input  pix_wr_t  wr_data,   // pixel queue head
    output logic     wr_pop,
    input  fb_addr_t rd_addr,
    output cidx_t    rd_cidx    // one cycle after rd_addr
);

    cidx_t mem [FB_PIXELS];

    // bitmap starts at colour 0
    initial begin
        for (int i = 0; i < FB_PIXELS; i++) begin
            mem[i] = '0;
        end
    end

    assign wr_pop = !wr_empty;  // drain every cycle there's data

    // write in the same cycle as the pop
    always_ff @(posedge clk_sys) begin
        if (wr_pop) mem[wr_data.addr] <= wr_data.cidx;  // addr pre-clipped
    end

    // read port
    always_ff @(posedge clk_sys) begin
        rd_cidx <= mem[rd_addr];
    end

endmodule

/* hw/scanout.sv */
// scanout: reads the whole bitmap in raster order on request,
// palette lookup and registered rgb stream with last flag
`timescale 1ns/1ns

module scanout import raster_pkg::*; (
    input  logic     clk_sys,
    input  logic     rst_sys,
    input  logic     scan_start,  // request a full frame
    input  logic     busy,        // drawing in progress
    output fb_addr_t rd_addr,
    input  cidx_t    rd_cidx,     // data for previous rd_addr
    output logic     pix_valid,
    output rgb_t     pix_rgb,
    output logic     pix_last
);

    localparam fb_addr_t LAST_ADDR = fb_addr_t'(FB_PIXELS - 1);

    fb_addr_t addr;      // next address, parked at 0 when idle
    logic     scanning;  // rd_cidx holds a frame pixel
    logic     start_ok;
    logic     rd_last;

    assign rd_addr  = addr;
    assign start_ok = scan_start && !busy && !scanning;  // ignored otherwise
    // addr wraps to 0 while the last pixel is on rd_cidx
    assign rd_last  = scanning && (addr == '0);

    // address counter and scan flag
    always_ff @(posedge clk_sys) begin
        if (rst_sys) begin
            addr     <= '0;
            scanning <= 1'b0;
        end else if (scanning) begin
            if (rd_last) begin
                scanning <= 1'b0;  // frame done, addr stays 0
            end else begin
                addr <= (addr == LAST_ADDR) ? '0 : addr + 1'b1;
            end
        end else if (start_ok) begin
            scanning <= 1'b1;  // pixel 0 read this cycle
            addr     <= fb_addr_t'(1);
        end
    end

    // output stage, aligned with palette register
    always_ff @(posedge clk_sys) begin
        if (rst_sys) begin
            pix_valid <= 1'b0;
            pix_last  <= 1'b0;
        end else begin
            pix_valid <= scanning;
            pix_last  <= rd_last;
        end
    end

    always_ff @(posedge clk_sys) begin
        pix_rgb <= palette_lookup(rd_cidx);  // payload, no reset
    end

endmodule

/* hw/line_raster_top.sv */
// line_raster_top: command queue, line renderer, pixel queue,
// framebuffer and scanout, plus the combined busy flag
`timescale 1ns/1ns

module line_raster_top import raster_pkg::*; #(
    parameter int CMD_DEPTH = 4,  // command queue entries
    parameter int PIX_DEPTH = 8   // pixel queue entries
) (
    input  logic      clk_sys,
    input  logic      rst_sys,
    input  logic      cmd_valid,   // send under credit
    input  line_cmd_t cmd,
    output logic      cmd_credit,  // one per command taken by renderer
    input  logic      scan_start,
    output logic      busy,        // drawing not finished
    output logic      pix_valid,   // rgb stream
    output rgb_t      pix_rgb,
    output logic      pix_last
);

    // command queue to renderer
    line_cmd_t cmd_head;
    logic      cmd_empty;
    logic      cmd_pop;

    // renderer to pixel queue
    logic      ren_valid;
    pix_wr_t   ren_pix;
    logic      pix_credit;
    logic      ren_active;

    // pixel queue to framebuffer
    pix_wr_t   pix_head;
    logic      pix_empty;
    logic      pix_pop;

    // scanout read port
    fb_addr_t  rd_addr;
    cidx_t     rd_cidx;

    credit_fifo #(.T(line_cmd_t), .DEPTH(CMD_DEPTH)) cmd_q (
        .clk_sys, .rst_sys,
        .in_valid(cmd_valid), .in_data(cmd),
        .pop(cmd_pop), .out_data(cmd_head),
        .empty(cmd_empty), .credit(cmd_credit)
    );

    line_render #(.PIX_DEPTH(PIX_DEPTH)) render (
        .clk_sys, .rst_sys,
        .cmd(cmd_head), .cmd_empty, .cmd_pop,
        .pix_valid(ren_valid), .pix(ren_pix),
        .pix_credit, .active(ren_active)
    );

    credit_fifo #(.T(pix_wr_t), .DEPTH(PIX_DEPTH)) pix_q (
        .clk_sys, .rst_sys,
        .in_valid(ren_valid), .in_data(ren_pix),
        .pop(pix_pop), .out_data(pix_head),
        .empty(pix_empty), .credit(pix_credit)
    );

    framebuffer fb (
        .clk_sys,
        .wr_empty(pix_empty), .wr_data(pix_head), .wr_pop(pix_pop),
        .rd_addr, .rd_cidx
    );

    // low once both queues drained and renderer idle
    assign busy = !cmd_empty || ren_active || !pix_empty;

    scanout scan (
        .clk_sys, .rst_sys,
        .scan_start, .busy,
        .rd_addr, .rd_cidx,
        .pix_valid, .pix_rgb, .pix_last
    );

endmodule

/* test/raster_checker.sv */
// assertions on command credits, scan stream framing
// and scan_start gating, bound into line_raster_top
`timescale 1ns/1ns

module raster_checker #(
    parameter int CMD_DEPTH = 4
) (
    input logic clk_sys,
    input logic rst_sys,
    input logic cmd_valid,
    input logic cmd_credit,
    input logic scan_start,
    input logic busy,
    input logic pix_valid,
    input logic pix_last
);

    int   credits;     // sender side view of command credits
    logic prev_start;  // scan_start one cycle back
    logic blocked;     // scan_start that must be ignored
    int   fails = 0;   // failed assertion count

    always_ff @(posedge clk_sys) begin
        if (rst_sys) begin
            credits    <= CMD_DEPTH;
            prev_start <= 1'b0;
        end else begin
            credits    <= credits - int'(cmd_valid) + int'(cmd_credit);
            prev_start <= scan_start;
        end
    end

    // a start one cycle earlier may legally be running already
    assign blocked = scan_start && busy && !pix_valid && !prev_start;

    assert property (@(posedge clk_sys) disable iff (rst_sys) cmd_valid |-> credits > 0)
        else begin
            $error("command sent without credit");
            fails++;
        end

    assert property (@(posedge clk_sys) disable iff (rst_sys) pix_valid && !pix_last |=> pix_valid)
        else begin
            $error("pix_valid dropped inside a frame");
            fails++;
        end

    assert property (@(posedge clk_sys) disable iff (rst_sys) pix_last |-> pix_valid)
        else begin
            $error("pix_last without pix_valid");
            fails++;
        end

    assert property (@(posedge clk_sys) disable iff (rst_sys) $past(blocked, 2) |-> !pix_valid)
        else begin
            $error("scan started while busy");
            fails++;
        end

endmodule

bind line_raster_top raster_checker #(.CMD_DEPTH(CMD_DEPTH)) proto_chk (
    .clk_sys(clk_sys),
    .rst_sys(rst_sys),
    .cmd_valid(cmd_valid),
    .cmd_credit(cmd_credit),
    .scan_start(scan_start),
    .busy(busy),
    .pix_valid(pix_valid),
    .pix_last(pix_last)
);

/* test/raster_monitor.sv */
// raster_monitor: compares the scan stream with the model bitmap,
// checks start latency, frame length, pix_last and credit totals
`timescale 1ns/1ns

module raster_monitor import raster_pkg::*; (
    input  logic  clk_sys,
    input  logic  rst_sys,
    input  logic  cmd_valid,
    input  logic  cmd_credit,
    input  logic  scan_start,
    input  logic  busy,
    input  logic  pix_valid,
    input  rgb_t  pix_rgb,
    input  logic  pix_last,
    input  cidx_t model [FB_PIXELS],  // reference bitmap
    output int    errors,
    output int    frames              // completed scans
);

    int   cyc, start_cyc, idx, cmd_cnt, credit_cnt;
    logic start_pending, in_frame, busy_q;
    rgb_t expected;

    always @(posedge clk_sys) begin
        if (rst_sys) begin
            {cyc, start_cyc, idx, cmd_cnt, credit_cnt, errors, frames} = '0;
            {start_pending, in_frame, busy_q} = '0;
        end else begin
            cyc++;
            if (pix_valid) begin
                if (!in_frame && !start_pending) begin
                    $display("pix_valid at %0t with no accepted scan_start", $time);
                    errors++;
                end else if (!in_frame && cyc - start_cyc != 2) begin
                    $display("mismatch at %0t: scan latency %0d cycles, expected 2",
                             $time, cyc - start_cyc);
                    errors++;
                end
                if (!in_frame) idx = 0;  // first pixel of a frame
                in_frame      = 1'b1;
                start_pending = 1'b0;
                expected = (idx < FB_PIXELS) ? palette_lookup(model[idx]) : '0;
                if (idx >= FB_PIXELS || pix_rgb !== expected) begin
                    $display("mismatch at %0t: pixel %0d rgb %h, expected %h",
                             $time, idx, pix_rgb, expected);
                    errors++;
                end
                if (pix_last !== (idx == FB_PIXELS - 1)) begin
                    $display("mismatch at %0t: pix_last %b on pixel %0d", $time, pix_last, idx);
                    errors++;
                end
                idx++;
            end else if (in_frame) begin
                in_frame = 1'b0;
                if (idx != FB_PIXELS) begin
                    $display("mismatch at %0t: frame of %0d pixels, expected %0d",
                             $time, idx, FB_PIXELS);
                    errors++;
                end
                frames++;
            end
            // honoured only when idle, same rule as the scanout
            if (scan_start && !busy && !in_frame && !start_pending) begin
                start_pending = 1'b1;
                start_cyc     = cyc;
            end
            // every queued command returned its credit once drawing ends
            if (busy_q && !busy && credit_cnt != cmd_cnt) begin
                $display("mismatch at %0t: %0d credits for %0d commands",
                         $time, credit_cnt, cmd_cnt);
                errors++;
            end
            if (cmd_credit && credit_cnt >= cmd_cnt) begin
                $display("cmd_credit at %0t with no command outstanding", $time);
                errors++;
            end
            cmd_cnt    += int'(cmd_valid);
            credit_cnt += int'(cmd_credit);
            busy_q      = busy;
        end
    end

endmodule

/* test/tb_line_raster.sv */
// clock, reset, LFSR stimulus, reference bitmap model,
// test sequence and closing summary
`timescale 1ns/1ns

module tb_line_raster import raster_pkg::*; ();

    localparam int CMD_DEPTH  = 4;
    localparam int PIX_DEPTH  = 2;     // shallow so the renderer runs out of pixel credit
    localparam int WAIT_LIMIT = 2000;  // cycles allowed for any single wait
    // octant test endpoints as offsets from the bitmap centre
    localparam int OX [16] = '{12, 0, -12, 0, 9, -9, 9, -9, 12, 5, -5, -12, -12, -5, 5, 12};
    localparam int OY [16] = '{0, 10, 0, -10, 9, 9, -9, -9, 5, 10, 10, 5, -5, -10, -10, -5};

    logic      clk_sys, rst_sys, cmd_valid, cmd_credit, scan_start, busy;
    logic      pix_valid, pix_last;
    line_cmd_t cmd;
    rgb_t      pix_rgb;
    cidx_t     model [FB_PIXELS];  // expected colour indices
    logic [15:0] lfsr_state;
    int sent, returned, tb_errors, mon_errors, frames, tests_run, tests_failed, mark;
    int a, b, c, d;

    line_raster_top #(.CMD_DEPTH(CMD_DEPTH), .PIX_DEPTH(PIX_DEPTH)) uut (
        .clk_sys, .rst_sys, .cmd_valid, .cmd, .cmd_credit,
        .scan_start, .busy, .pix_valid, .pix_rgb, .pix_last
    );

    raster_monitor mon (
        .clk_sys, .rst_sys, .cmd_valid, .cmd_credit, .scan_start, .busy,
        .pix_valid, .pix_rgb, .pix_last, .model, .errors(mon_errors), .frames
    );

    always #10 clk_sys = ~clk_sys;

    always @(posedge clk_sys) begin
        if (rst_sys) returned <= 0;
        else if (cmd_credit) returned <= returned + 1;  // credits back from DUT
    end

    // x^16 + x^14 + x^13 + x^11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic int rand_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);  // one step per bit
            v = (v << 1) | int'(lfsr_state[0]);
        end
        return v;
    endfunction

    function automatic int rand_range(input int lo, input int hi);
        return lo + rand_bits(8) % (hi - lo + 1);
    endfunction

    // monitor, testbench and bound assertion failures together
    function automatic int error_total();
        return mon_errors + tb_errors + uut.proto_chk.fails;
    endfunction

    // Bresenham walk with per pixel clipping
    function automatic void paint_line(input int x0, y0, x1, y1, input cidx_t col);
        int dx, dy, sx, sy, err, e2, x, y;
        dx  = (x1 > x0) ? x1 - x0 : x0 - x1;
        dy  = (y1 > y0) ? y0 - y1 : y1 - y0;  // negated span
        sx  = (x1 < x0) ? -1 : 1;
        sy  = (y1 < y0) ? -1 : 1;
        err = dx + dy;
        x   = x0;
        y   = y0;
        for (int n = 0; n < 256; n++) begin
            if (x >= 0 && x < FB_W && y >= 0 && y < FB_H) model[y * FB_W + x] = col;
            if (x == x1 && y == y1) break;
            e2 = 2 * err;
            if (e2 >= dy) begin
                err += dy;
                x   += sx;
            end
            if (e2 <= dx) begin
                err += dx;
                y   += sy;
            end
        end
    endfunction

    task automatic send_line(input int x0, y0, x1, y1, col);
        int t;
        t = 0;
        while (CMD_DEPTH - sent + returned <= 0 && t < WAIT_LIMIT) begin
            @(posedge clk_sys);
            #2;
            t++;
        end
        if (CMD_DEPTH - sent + returned <= 0) begin
            $display("timeout: no command credit came back, line dropped");
            tb_errors++;
        end else begin
            cmd_valid = 1'b1;
            cmd.x0 = coord_t'(x0);
            cmd.y0 = coord_t'(y0);
            cmd.x1 = coord_t'(x1);
            cmd.y1 = coord_t'(y1);
            cmd.cidx = cidx_t'(col);
            paint_line(x0, y0, x1, y1, cidx_t'(col));  // commands draw in order
            @(posedge clk_sys);
            #2;
            cmd_valid = 1'b0;
            sent++;
        end
    endtask

    task automatic pulse_start();
        scan_start = 1'b1;
        @(posedge clk_sys);
        #2;
        scan_start = 1'b0;
    endtask

    task automatic wait_idle();
        int t;
        t = 0;
        @(posedge clk_sys);
        #2;
        while (busy && t < WAIT_LIMIT) begin
            @(posedge clk_sys);
            #2;
            t++;
        end
        if (busy) begin
            $display("timeout: busy still high after %0d cycles", t);
            tb_errors++;
        end
    endtask

    task automatic run_scan();
        int f0, t;
        f0 = frames;
        t  = 0;
        pulse_start();
        while (frames == f0 && t < WAIT_LIMIT) begin
            @(posedge clk_sys);
            #2;
            t++;
        end
        if (frames == f0) begin
            $display("timeout: scan frame never completed");
            tb_errors++;
        end
    endtask

    task automatic end_test(input string name);
        int errs;
        errs = error_total() - mark;
        tests_run++;
        if (errs == 0) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            $display("test %0d %s: failed with %0d errors", tests_run, name, errs);
            tests_failed++;
        end
        mark = error_total();
    endtask

    initial begin
        clk_sys    = 1'b0;
        rst_sys    = 1'b1;
        cmd_valid  = 1'b0;
        cmd        = '0;
        scan_start = 1'b0;
        lfsr_state = 16'd50755;
        {sent, tb_errors, tests_run, tests_failed, mark} = '0;
        for (int i = 0; i < FB_PIXELS; i++) model[i] = '0;  // matches memory init
        repeat (2) @(posedge clk_sys);
        #2 rst_sys = 1'b0;

        send_line(7, 5, 7, 5, 3);
        wait_idle();
        run_scan();
        end_test("single point");

        for (int i = 0; i < 16; i++) send_line(16, 12, 16 + OX[i], 12 + OY[i], i % 15 + 1);
        wait_idle();
        run_scan();
        end_test("octants");

        for (int i = 0; i < 20; i++) begin
            a = rand_range(-8, 39);
            b = rand_range(-8, 39);
            c = rand_range(-8, 39);
            d = rand_range(-8, 39);
            send_line(a, b, c, d, rand_bits(4));
        end
        wait_idle();
        run_scan();
        end_test("clipped random lines");

        for (int i = 0; i < 24; i++) begin
            a = rand_range(0, FB_W - 1);
            b = rand_range(0, FB_H - 1);
            c = rand_range(0, FB_W - 1);
            d = rand_range(0, FB_H - 1);
            send_line(a, b, c, d, rand_bits(4));
            if (i == 3) pulse_start();  // drawing still busy so this start is ignored
        end
        wait_idle();
        run_scan();
        end_test("credit stress");

        send_line(0, 0, 31, 23, 5);
        send_line(0, 23, 31, 0, 9);
        send_line(0, 12, 31, 12, 12);  // crosses both diagonals
        wait_idle();
        run_scan();
        end_test("overlap order");

        run_scan();
        run_scan();
        end_test("scan framing");

        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed,
                 error_total());
        if (tests_failed == 0 && error_total() == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

/* compile.f */
hw/raster_pkg.sv
hw/credit_fifo.sv
hw/line_render.sv
hw/framebuffer.sv
hw/scanout.sv
hw/line_raster_top.sv
test/raster_checker.sv
test/raster_monitor.sv
test/tb_line_raster.sv

/* run_sim.sh */
#!/bin/sh
# build and run the line raster testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_line_raster -f compile.f

out=$(./obj_dir/Vtb_line_raster) || true
echo "$out"

if echo "$out" | grep -qx "sim passed"; then
    exit 0
else
    exit 1
fi
